//--- src/rvCore_cfg.svh
`ifndef RVCORE_CFG_SVH
`define RVCORE_CFG_SVH

// core geometry.
`define XLEN 64
`define NUM_REGS 32

// first fetch after reset.
`define RESET_PC 64'h80000000

// machine-mode CSR addresses.
`define CSR_MTVEC 12'h305
`define CSR_MEPC 12'h341
`define CSR_MCAUSE 12'h342

// mcause values for synchronous exceptions.
`define CAUSE_ILLEGAL 64'd2
`define CAUSE_ECALL_M 64'd11

`endif

//--- src/rvCorePkg.sv
`default_nettype none

`include "rvCore_cfg.svh"

package rvCorePkg;

  // ##################################################
  // vector types
  // ##################################################
  typedef logic [`XLEN-1:0] xlenT;
  typedef logic [31:0] instT;
  typedef logic [4:0] regAddrT;
  typedef logic [11:0] csrAddrT;
  typedef logic [`XLEN/8-1:0] byteMaskT;

  // ##################################################
  // encodings
  // ##################################################
  typedef enum logic [6:0] {
    OP_LOAD   = 7'b0000011,
    OP_IMM    = 7'b0010011,
    OP_AUIPC  = 7'b0010111,
    OP_STORE  = 7'b0100011,
    OP_REG    = 7'b0110011,
    OP_LUI    = 7'b0110111,
    OP_BRANCH = 7'b1100011,
    OP_JALR   = 7'b1100111,
    OP_JAL    = 7'b1101111,
    OP_SYSTEM = 7'b1110011
  } opcodeE;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
    ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_COPYB
  } aluOpE;

  typedef enum logic [3:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR
  } branchE;

  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PCPLUS4, WB_CSR} wbSelE;

  typedef enum logic [1:0] {CSROP_NONE, CSROP_WRITE, CSROP_SET} csrOpE;

  // decoded control for one instruction.
  typedef struct packed {
    aluOpE aluOp;
    logic srcAIsPc;
    logic srcBIsImm;
    branchE branch;
    wbSelE wbSel;
    logic regWrite;
    logic memRead;
    logic memWrite;
    logic memWord;
    csrOpE csrOp;
    logic ecall;
    logic mret;
    logic illegal;
  } ctrlT;

endpackage

`default_nettype wire

//--- src/regFile.sv
`default_nettype none

`include "rvCore_cfg.svh"

module regFile (
  input wire logic clk,
  input wire logic reset,
  input wire rvCorePkg::regAddrT rs1Addr,
  input wire rvCorePkg::regAddrT rs2Addr,
  input wire rvCorePkg::regAddrT rdAddr,
  input wire logic rdWrite,
  input wire rvCorePkg::xlenT rdData,
  output rvCorePkg::xlenT rs1Data,
  output rvCorePkg::xlenT rs2Data
);

  rvCorePkg::xlenT regs [`NUM_REGS];

  // x0 is never written, so it reads zero after reset.
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rdWrite && (rdAddr != '0)) begin
      regs[rdAddr] <= rdData;
    end
  end

  // combinational read ports.
  assign rs1Data = regs[rs1Addr];
  assign rs2Data = regs[rs2Addr];

endmodule

`default_nettype wire

//--- src/instDecoder.sv
`default_nettype none

module instDecoder (
  input wire rvCorePkg::instT inst,
  output rvCorePkg::ctrlT ctrl,
  output rvCorePkg::xlenT imm
);

  logic [2:0] funct3;
  logic [6:0] funct7;
  rvCorePkg::xlenT immI;
  rvCorePkg::xlenT immS;
  rvCorePkg::xlenT immB;
  rvCorePkg::xlenT immU;
  rvCorePkg::xlenT immJ;

  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // ##################################################
  // immediates, all sign-extended from bit 31
  // ##################################################
  assign immI = {{52{inst[31]}}, inst[31:20]};
  assign immS = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign immB = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign immU = {{32{inst[31]}}, inst[31:12], 12'b0};
  assign immJ = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // shared funct3 map of OP and OP-IMM.
  function automatic rvCorePkg::aluOpE aluFromFunct3(input logic [2:0] f3);
    case (f3)
      3'b000: return rvCorePkg::ALU_ADD;
      3'b001: return rvCorePkg::ALU_SLL;
      3'b010: return rvCorePkg::ALU_SLT;
      3'b011: return rvCorePkg::ALU_SLTU;
      3'b100: return rvCorePkg::ALU_XOR;
      3'b101: return rvCorePkg::ALU_SRL;
      3'b110: return rvCorePkg::ALU_OR;
      default: return rvCorePkg::ALU_AND;
    endcase
  endfunction

  // ##################################################
  // control decode
  // ##################################################
  always_comb begin
    ctrl = '0;
    imm = '0;
    case (rvCorePkg::opcodeE'(inst[6:0]))
      rvCorePkg::OP_LUI: begin
        ctrl.aluOp = rvCorePkg::ALU_COPYB;
        ctrl.srcBIsImm = 1'b1;
        ctrl.regWrite = 1'b1;
        imm = immU;
      end
      rvCorePkg::OP_AUIPC: begin
        ctrl.srcAIsPc = 1'b1;
        ctrl.srcBIsImm = 1'b1;
        ctrl.regWrite = 1'b1;
        imm = immU;
      end
      rvCorePkg::OP_JAL: begin
        ctrl.branch = rvCorePkg::BR_JAL;
        ctrl.wbSel = rvCorePkg::WB_PCPLUS4;
        ctrl.regWrite = 1'b1;
        imm = immJ;
      end
      rvCorePkg::OP_JALR: begin
        imm = immI;
        if (funct3 == 3'b000) begin
          ctrl.branch = rvCorePkg::BR_JALR;
          ctrl.wbSel = rvCorePkg::WB_PCPLUS4;
          ctrl.regWrite = 1'b1;
        end else begin
          ctrl.illegal = 1'b1;
        end
      end
      rvCorePkg::OP_BRANCH: begin
        imm = immB;
        case (funct3)
          3'b000: ctrl.branch = rvCorePkg::BR_EQ;
          3'b001: ctrl.branch = rvCorePkg::BR_NE;
          3'b100: ctrl.branch = rvCorePkg::BR_LT;
          3'b101: ctrl.branch = rvCorePkg::BR_GE;
          3'b110: ctrl.branch = rvCorePkg::BR_LTU;
          3'b111: ctrl.branch = rvCorePkg::BR_GEU;
          default: ctrl.illegal = 1'b1;
        endcase
      end
      rvCorePkg::OP_LOAD: begin
        imm = immI;
        if (funct3 == 3'b011 || funct3 == 3'b010) begin
          ctrl.srcBIsImm = 1'b1;
          ctrl.memRead = 1'b1;
          ctrl.memWord = (funct3 == 3'b010);
          ctrl.wbSel = rvCorePkg::WB_MEM;
          ctrl.regWrite = 1'b1;
        end else begin
          ctrl.illegal = 1'b1;
        end
      end
      rvCorePkg::OP_STORE: begin
        imm = immS;
        if (funct3 == 3'b011 || funct3 == 3'b010) begin
          ctrl.srcBIsImm = 1'b1;
          ctrl.memWrite = 1'b1;
          ctrl.memWord = (funct3 == 3'b010);
        end else begin
          ctrl.illegal = 1'b1;
        end
      end
      rvCorePkg::OP_IMM: begin
        imm = immI;
        ctrl.srcBIsImm = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.aluOp = aluFromFunct3(funct3);
        // rv64 shifts keep a 6-bit shamt, funct6 above it.
        if (funct3 == 3'b101 && inst[31:26] == 6'b010000) begin
          ctrl.aluOp = rvCorePkg::ALU_SRA;
        end else if ((funct3 == 3'b001 || funct3 == 3'b101) && inst[31:26] != 6'b0) begin
          ctrl = '0;
          ctrl.illegal = 1'b1;
        end
      end
      rvCorePkg::OP_REG: begin
        ctrl.regWrite = 1'b1;
        if (funct7 == 7'b0000000) begin
          ctrl.aluOp = aluFromFunct3(funct3);
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          ctrl.aluOp = rvCorePkg::ALU_SUB;
        end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
          ctrl.aluOp = rvCorePkg::ALU_SRA;
        end else begin
          ctrl.regWrite = 1'b0;
          ctrl.illegal = 1'b1;
        end
      end
      rvCorePkg::OP_SYSTEM: begin
        case (funct3)
          3'b001, 3'b010: begin
            ctrl.csrOp = (funct3 == 3'b001) ? rvCorePkg::CSROP_WRITE : rvCorePkg::CSROP_SET;
            ctrl.wbSel = rvCorePkg::WB_CSR;
            ctrl.regWrite = 1'b1;
          end
          3'b000: begin
            if (inst == 32'h00000073) begin
              ctrl.ecall = 1'b1;
            end else if (inst == 32'h30200073) begin
              ctrl.mret = 1'b1;
            end else begin
              ctrl.illegal = 1'b1;
            end
          end
          default: ctrl.illegal = 1'b1;
        endcase
      end
      default: ctrl.illegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

//--- src/alu.sv
`default_nettype none

module alu (
  input wire rvCorePkg::ctrlT ctrl,
  input wire rvCorePkg::xlenT pc,
  input wire rvCorePkg::xlenT rs1Data,
  input wire rvCorePkg::xlenT rs2Data,
  input wire rvCorePkg::xlenT imm,
  output rvCorePkg::xlenT result,
  output rvCorePkg::xlenT target,
  output logic taken
);

  rvCorePkg::xlenT opA;
  rvCorePkg::xlenT opB;
  logic [5:0] shamt;

  assign opA = ctrl.srcAIsPc ? pc : rs1Data;
  assign opB = ctrl.srcBIsImm ? imm : rs2Data;
  assign shamt = opB[5:0];

  always_comb begin
    case (ctrl.aluOp)
      rvCorePkg::ALU_SUB: result = opA - opB;
      rvCorePkg::ALU_AND: result = opA & opB;
      rvCorePkg::ALU_OR: result = opA | opB;
      rvCorePkg::ALU_XOR: result = opA ^ opB;
      rvCorePkg::ALU_SLL: result = opA << shamt;
      rvCorePkg::ALU_SRL: result = opA >> shamt;
      rvCorePkg::ALU_SRA: result = rvCorePkg::xlenT'($signed(opA) >>> shamt);
      rvCorePkg::ALU_SLT: result = {63'b0, $signed(opA) < $signed(opB)};
      rvCorePkg::ALU_SLTU: result = {63'b0, opA < opB};
      rvCorePkg::ALU_COPYB: result = opB;
      default: result = opA + opB;
    endcase
  end

  // jalr target drops bit 0.
  assign target = (ctrl.branch == rvCorePkg::BR_JALR) ? ((rs1Data + imm) & ~64'd1) : (pc + imm);

  always_comb begin
    case (ctrl.branch)
      rvCorePkg::BR_EQ: taken = (rs1Data == rs2Data);
      rvCorePkg::BR_NE: taken = (rs1Data != rs2Data);
      rvCorePkg::BR_LT: taken = ($signed(rs1Data) < $signed(rs2Data));
      rvCorePkg::BR_GE: taken = ($signed(rs1Data) >= $signed(rs2Data));
      rvCorePkg::BR_LTU: taken = (rs1Data < rs2Data);
      rvCorePkg::BR_GEU: taken = (rs1Data >= rs2Data);
      rvCorePkg::BR_JAL, rvCorePkg::BR_JALR: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- src/pcUnit.sv
`default_nettype none

`include "rvCore_cfg.svh"

module pcUnit (
  input wire logic clk,
  input wire logic reset,
  input wire logic taken,
  input wire rvCorePkg::xlenT target,
  input wire logic trap,
  input wire logic mret,
  input wire rvCorePkg::xlenT mtvec,
  input wire rvCorePkg::xlenT mepc,
  output rvCorePkg::xlenT pc
);

  rvCorePkg::xlenT nextPc;

  // trap wins over mret, mret over a taken branch.
  always_comb begin
    if (trap) begin
      nextPc = mtvec;
    end else if (mret) begin
      nextPc = mepc;
    end else if (taken) begin
      nextPc = target;
    end else begin
      nextPc = pc + 64'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `RESET_PC;
    end else begin
      pc <= nextPc;
    end
  end

endmodule

`default_nettype wire

//--- src/csrFile.sv
`default_nettype none

`include "rvCore_cfg.svh"

module csrFile (
  input wire logic clk,
  input wire logic reset,
  input wire rvCorePkg::csrAddrT csrAddr,
  input wire rvCorePkg::csrOpE csrOp,
  input wire rvCorePkg::xlenT wdata,
  input wire logic trap,
  input wire rvCorePkg::xlenT cause,
  input wire logic mret,
  input wire rvCorePkg::xlenT pc,
  output rvCorePkg::xlenT csrRdata,
  output rvCorePkg::xlenT mtvec,
  output rvCorePkg::xlenT mepc
);

  rvCorePkg::xlenT mcause;
  rvCorePkg::xlenT newValue;
  logic swWrite;

  // unknown addresses read zero.
  always_comb begin
    case (csrAddr)
      `CSR_MTVEC: csrRdata = mtvec;
      `CSR_MEPC: csrRdata = mepc;
      `CSR_MCAUSE: csrRdata = mcause;
      default: csrRdata = '0;
    endcase
  end

  assign newValue = (csrOp == rvCorePkg::CSROP_SET) ? (csrRdata | wdata) : wdata;
  assign swWrite = (csrOp != rvCorePkg::CSROP_NONE) && !trap && !mret;

  always_ff @(posedge clk) begin
    if (reset) begin
      mtvec <= '0;
      mepc <= '0;
      mcause <= '0;
    end else if (trap) begin
      mepc <= pc;
      mcause <= cause;
    end else if (swWrite) begin
      case (csrAddr)
        `CSR_MTVEC: mtvec <= newValue;
        `CSR_MEPC: mepc <= newValue;
        `CSR_MCAUSE: mcause <= newValue;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/rvCore.sv
`default_nettype none

`include "rvCore_cfg.svh"

module rvCore (
  input wire logic clk,
  input wire logic reset,
  output rvCorePkg::xlenT instAddr,
  input wire rvCorePkg::instT inst,
  output rvCorePkg::xlenT dataAddr,
  output rvCorePkg::xlenT dataWdata,
  output rvCorePkg::byteMaskT dataMask,
  output logic dataRead,
  output logic dataWrite,
  input wire rvCorePkg::xlenT dataRdata
);

  rvCorePkg::ctrlT ctrl;
  rvCorePkg::xlenT imm;
  rvCorePkg::xlenT pc;
  rvCorePkg::xlenT pcPlus4;
  rvCorePkg::xlenT rs1Data;
  rvCorePkg::xlenT rs2Data;
  rvCorePkg::xlenT aluResult;
  rvCorePkg::xlenT target;
  rvCorePkg::xlenT csrRdata;
  rvCorePkg::xlenT mtvec;
  rvCorePkg::xlenT mepc;
  rvCorePkg::xlenT cause;
  rvCorePkg::xlenT loadData;
  rvCorePkg::xlenT wbData;
  logic taken;
  logic trap;

  // ##################################################
  // datapath blocks
  // ##################################################
  pcUnit i_pcUnit (
    .clk(clk), .reset(reset), .taken(taken), .target(target), .trap(trap),
    .mret(ctrl.mret), .mtvec(mtvec), .mepc(mepc), .pc(pc)
  );

  instDecoder i_instDecoder (.inst(inst), .ctrl(ctrl), .imm(imm));

  regFile i_regFile (
    .clk(clk), .reset(reset),
    .rs1Addr(rvCorePkg::regAddrT'(inst[19:15])),
    .rs2Addr(rvCorePkg::regAddrT'(inst[24:20])),
    .rdAddr(rvCorePkg::regAddrT'(inst[11:7])),
    .rdWrite(ctrl.regWrite && !trap), .rdData(wbData),
    .rs1Data(rs1Data), .rs2Data(rs2Data)
  );

  alu i_alu (
    .ctrl(ctrl), .pc(pc), .rs1Data(rs1Data), .rs2Data(rs2Data), .imm(imm),
    .result(aluResult), .target(target), .taken(taken)
  );

  csrFile i_csrFile (
    .clk(clk), .reset(reset), .csrAddr(rvCorePkg::csrAddrT'(inst[31:20])),
    .csrOp(ctrl.csrOp), .wdata(rs1Data), .trap(trap), .cause(cause),
    .mret(ctrl.mret), .pc(pc), .csrRdata(csrRdata), .mtvec(mtvec), .mepc(mepc)
  );

  // ##################################################
  // traps, data port and write-back
  // ##################################################
  assign trap = ctrl.ecall || ctrl.illegal;
  assign cause = ctrl.illegal ? `CAUSE_ILLEGAL : `CAUSE_ECALL_M;

  assign instAddr = pc;
  assign pcPlus4 = pc + 64'd4;

  // no memory traffic while reset is held.
  assign dataAddr = aluResult;
  assign dataWdata = rs2Data;
  assign dataMask = ctrl.memWord ? 8'h0F : 8'hFF;
  assign dataRead = ctrl.memRead && !reset;
  assign dataWrite = ctrl.memWrite && !reset;

  // lw sign-extends from bit 31.
  assign loadData = ctrl.memWord ? {{32{dataRdata[31]}}, dataRdata[31:0]} : dataRdata;

  always_comb begin
    case (ctrl.wbSel)
      rvCorePkg::WB_MEM: wbData = loadData;
      rvCorePkg::WB_PCPLUS4: wbData = pcPlus4;
      rvCorePkg::WB_CSR: wbData = csrRdata;
      default: wbData = aluResult;
    endcase
  end

endmodule

`default_nettype wire

//--- verification/clockGen.sv
`default_nettype none

module clockGen (
  output logic clk,
  output logic reset
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // reset held for 16 cycles, released on a falling edge.
  initial begin
    reset = 1'b1;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

//--- verification/rvCore_props.sv
`default_nettype none

`include "rvCore_cfg.svh"

module rvCoreProps (
  input wire logic clk,
  input wire logic reset,
  input wire rvCorePkg::xlenT instAddr,
  input wire logic dataWrite,
  input wire rvCorePkg::byteMaskT dataMask,
  input wire rvCorePkg::ctrlT ctrl,
  input wire logic taken,
  input wire rvCorePkg::xlenT target,
  input wire logic trap,
  input wire rvCorePkg::xlenT mtvec,
  input wire rvCorePkg::xlenT mepc
);

  timeunit 1ns;
  timeprecision 100ps;

  int failCount = 0;

  // first fetch after reset.
  firstFetch: assert property (@(posedge clk) $fell(reset) |-> instAddr == `RESET_PC)
    else begin
      failCount++;
      $error("first fetch after reset is not at the reset PC");
    end

  noStoreInReset: assert property (@(posedge clk) reset |-> !dataWrite)
    else begin
      failCount++;
      $error("store issued while reset is held");
    end

  nonZeroMask: assert property (@(posedge clk) dataWrite |-> dataMask != '0)
    else begin
      failCount++;
      $error("store issued with an empty byte mask");
    end

  // ##################################################
  // next fetch address
  // ##################################################
  takenTarget: assert property (@(posedge clk) disable iff (reset)
    (!trap && !ctrl.mret && taken) |=> instAddr == $past(target))
    else begin
      failCount++;
      $error("taken branch or jump did not fetch its target");
    end

  sequential: assert property (@(posedge clk) disable iff (reset)
    (!trap && !ctrl.mret && !taken) |=> instAddr == $past(instAddr) + 64'd4)
    else begin
      failCount++;
      $error("sequential instruction did not fetch pc+4");
    end

  trapVector: assert property (@(posedge clk) disable iff (reset)
    trap |=> instAddr == $past(mtvec))
    else begin
      failCount++;
      $error("trap did not fetch from mtvec");
    end

  mretReturn: assert property (@(posedge clk) disable iff (reset)
    (ctrl.mret && !trap) |=> instAddr == $past(mepc))
    else begin
      failCount++;
      $error("mret did not return to mepc");
    end

endmodule

bind rvCore rvCoreProps i_props (
  .clk(clk), .reset(reset), .instAddr(instAddr), .dataWrite(dataWrite),
  .dataMask(dataMask), .ctrl(ctrl), .taken(taken), .target(target),
  .trap(trap), .mtvec(mtvec), .mepc(mepc)
);

`default_nettype wire

//--- verification/rvCoreTb.sv
`default_nettype none

`include "rvCore_cfg.svh"

module rvCoreTb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [63:0] DATA_BASE = 64'h10000;
  localparam int HANDLER_OFF = 'h400;
  localparam logic [31:0] NOP = 32'h00000013;

  logic clk;
  logic reset;
  rvCorePkg::xlenT instAddr;
  rvCorePkg::instT inst;
  rvCorePkg::xlenT dataAddr;
  rvCorePkg::xlenT dataWdata;
  rvCorePkg::byteMaskT dataMask;
  logic dataRead;
  logic dataWrite;
  rvCorePkg::xlenT dataRdata;

  logic [31:0] progImage [int];
  logic [63:0] dataMem [logic [63:0]];
  logic [63:0] expAddr [$];
  logic [63:0] expData [$];
  logic [7:0] expMask [$];
  int progIdx = 0;
  int nextSlot = 0;
  int errors = 0;
  logic [31:0] rngState = 32'h338ce165;
  logic [63:0] endPc;
  logic [63:0] lastA;
  logic [63:0] lastB;

  clockGen i_clockGen (.clk(clk), .reset(reset));

  rvCore i_dut (
    .clk(clk), .reset(reset), .instAddr(instAddr), .inst(inst),
    .dataAddr(dataAddr), .dataWdata(dataWdata), .dataMask(dataMask),
    .dataRead(dataRead), .dataWrite(dataWrite), .dataRdata(dataRdata)
  );

  // ##################################################
  // helpers
  // ##################################################
  function automatic logic [31:0] nextRandom();
    rngState = rngState * 32'd1664525 + 32'd1013904223;
    return rngState;
  endfunction

  function automatic logic [63:0] sext32(input logic [31:0] v);
    return {{32{v[31]}}, v};
  endfunction

  function automatic logic [63:0] sext12(input logic [11:0] v);
    return {{52{v[11]}}, v};
  endfunction

  function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
                                       input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // integer result for a funct3 where alt selects sub and sra.
  function automatic logic [63:0] opResult(input logic [2:0] f3, input logic alt,
                                           input logic [63:0] a, input logic [63:0] b);
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[5:0];
      3'b010: return {63'b0, $signed(a) < $signed(b)};
      3'b011: return {63'b0, a < b};
      3'b100: return a ^ b;
      3'b101: begin
        if (alt) begin
          return $signed(a) >>> b[5:0];
        end
        return a >> b[5:0];
      end
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branchTaken(input logic [2:0] f3, input logic [63:0] a,
                                       input logic [63:0] b);
    case (f3)
      3'b000: return a == b;
      3'b001: return a != b;
      3'b100: return $signed(a) < $signed(b);
      3'b101: return $signed(a) >= $signed(b);
      3'b110: return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [63:0] maskBits(input logic [7:0] mask);
    logic [63:0] bits;
    for (int i = 0; i < 8; i++) begin
      bits[8*i +: 8] = {8{mask[i]}};
    end
    return bits;
  endfunction

  function automatic logic [63:0] curPc();
    return `RESET_PC + 64'(4 * progIdx);
  endfunction

  // ##################################################
  // program construction
  // ##################################################
  task automatic emit(input logic [31:0] w);
    progImage[progIdx] = w;
    progIdx++;
  endtask

  task automatic expectStore(input logic [63:0] addr, input logic [63:0] data,
                             input logic [7:0] mask);
    expAddr.push_back(addr);
    expData.push_back(data);
    expMask.push_back(mask);
  endtask

  task automatic storeDword(input logic [4:0] rs2, input logic [63:0] value);
    emit(encS(12'(nextSlot), rs2, 5'd31, 3'b011));
    expectStore(DATA_BASE + 64'(nextSlot), value, 8'hFF);
    nextSlot += 8;
  endtask

  // lui and addi pair with the value the ISA forms.
  task automatic loadImm(input logic [4:0] rd, input logic [31:0] v, output logic [63:0] val);
    logic [31:0] upperSum;
    upperSum = v + 32'h800;
    emit(encU(upperSum[31:12], rd, rvCorePkg::OP_LUI));
    emit(encI(v[11:0], rd, 3'b000, rd, rvCorePkg::OP_IMM));
    val = sext32({upperSum[31:12], 12'b0}) + sext12(v[11:0]);
  endtask

  task automatic aluRound();
    logic [63:0] a;
    logic [63:0] b;
    logic [31:0] r;
    logic [2:0] immOps [6];
    loadImm(5'd1, nextRandom(), a);
    loadImm(5'd2, nextRandom(), b);
    for (int f3 = 0; f3 < 8; f3++) begin
      emit(encR(7'b0, 5'd2, 5'd1, 3'(f3), 5'd3));
      storeDword(5'd3, opResult(3'(f3), 1'b0, a, b));
    end
    emit(encR(7'b0100000, 5'd2, 5'd1, 3'b000, 5'd3));
    storeDword(5'd3, opResult(3'b000, 1'b1, a, b));
    emit(encR(7'b0100000, 5'd2, 5'd1, 3'b101, 5'd3));
    storeDword(5'd3, opResult(3'b101, 1'b1, a, b));
    immOps = '{3'b000, 3'b010, 3'b011, 3'b100, 3'b110, 3'b111};
    r = nextRandom();
    foreach (immOps[i]) begin
      emit(encI(r[11:0], 5'd1, immOps[i], 5'd3, rvCorePkg::OP_IMM));
      storeDword(5'd3, opResult(immOps[i], 1'b0, a, sext12(r[11:0])));
    end
    // shifts by a 6-bit amount.
    r = nextRandom();
    emit(encI({6'b0, r[5:0]}, 5'd1, 3'b001, 5'd3, rvCorePkg::OP_IMM));
    storeDword(5'd3, opResult(3'b001, 1'b0, a, {58'b0, r[5:0]}));
    emit(encI({6'b0, r[5:0]}, 5'd1, 3'b101, 5'd3, rvCorePkg::OP_IMM));
    storeDword(5'd3, opResult(3'b101, 1'b0, a, {58'b0, r[5:0]}));
    emit(encI({6'b010000, r[5:0]}, 5'd1, 3'b101, 5'd3, rvCorePkg::OP_IMM));
    storeDword(5'd3, opResult(3'b101, 1'b1, a, {58'b0, r[5:0]}));
    lastA = a;
    lastB = b;
  endtask

  task automatic branchCase(input logic [2:0] f3, input logic [4:0] rsA, input logic [4:0] rsB,
                            input logic [63:0] valA, input logic [63:0] valB);
    emit(encI(12'd1, 5'd0, 3'b000, 5'd11, rvCorePkg::OP_IMM));
    emit(encB(13'd8, rsB, rsA, f3));
    emit(encI(12'd2, 5'd0, 3'b000, 5'd11, rvCorePkg::OP_IMM));
    storeDword(5'd11, branchTaken(f3, valA, valB) ? 64'd1 : 64'd2);
  endtask

  task automatic trapCase(input logic [31:0] w, input logic [63:0] cause,
                          input logic [11:0] marker);
    expectStore(DATA_BASE + 64'h700, curPc(), 8'hFF);
    expectStore(DATA_BASE + 64'h708, cause, 8'hFF);
    emit(w);
    // execution resumes here after mret.
    emit(encI(marker, 5'd0, 3'b000, 5'd17, rvCorePkg::OP_IMM));
    storeDword(5'd17, 64'(marker));
  endtask

  task automatic buildProgram();
    logic [63:0] p;
    logic [63:0] c;
    logic [2:0] brOps [6];
    int slot;
    // a store sits at the reset PC while reset is held.
    emit(encS(12'h0, 5'd0, 5'd0, 3'b011));
    expectStore(64'd0, 64'd0, 8'hFF);
    emit(encU(20'h00010, 5'd31, rvCorePkg::OP_LUI));
    p = curPc();
    emit(encU(20'h0, 5'd5, rvCorePkg::OP_AUIPC));
    emit(encI(12'(HANDLER_OFF - int'(p - `RESET_PC)), 5'd5, 3'b000, 5'd5, rvCorePkg::OP_IMM));
    emit(encI(`CSR_MTVEC, 5'd5, 3'b001, 5'd0, rvCorePkg::OP_SYSTEM));
    emit(encI(`CSR_MTVEC, 5'd0, 3'b010, 5'd16, rvCorePkg::OP_SYSTEM));
    storeDword(5'd16, `RESET_PC + 64'(HANDLER_OFF));
    aluRound();
    aluRound();

    // loads, byte mask and x0.
    slot = nextSlot;
    storeDword(5'd1, lastA);
    emit(encI(12'(slot), 5'd31, 3'b011, 5'd4, rvCorePkg::OP_LOAD));
    storeDword(5'd4, lastA);
    loadImm(5'd8, nextRandom() | 32'h80000000, c);
    slot = nextSlot;
    storeDword(5'd8, c);
    emit(encI(12'(slot), 5'd31, 3'b010, 5'd9, rvCorePkg::OP_LOAD));
    storeDword(5'd9, sext32(c[31:0]));
    slot = nextSlot;
    storeDword(5'd1, lastA);
    emit(encS(12'(slot), 5'd2, 5'd31, 3'b010));
    expectStore(DATA_BASE + 64'(slot), {32'b0, lastB[31:0]}, 8'h0F);
    emit(encI(12'(slot), 5'd31, 3'b011, 5'd10, rvCorePkg::OP_LOAD));
    storeDword(5'd10, {lastA[63:32], lastB[31:0]});
    emit(encI(12'd5, 5'd1, 3'b000, 5'd0, rvCorePkg::OP_IMM));
    storeDword(5'd0, 64'd0);

    brOps = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    foreach (brOps[i]) begin
      branchCase(brOps[i], 5'd1, 5'd2, lastA, lastB);
      branchCase(brOps[i], 5'd2, 5'd1, lastB, lastA);
      branchCase(brOps[i], 5'd1, 5'd1, lastA, lastA);
    end

    // jal skips one instruction.
    p = curPc();
    emit(encJ(21'd8, 5'd12));
    emit(encI(12'd7, 5'd0, 3'b000, 5'd13, rvCorePkg::OP_IMM));
    storeDword(5'd12, p + 64'd4);
    storeDword(5'd13, 64'd0);
    // jalr with an odd offset.
    p = curPc();
    emit(encU(20'h0, 5'd14, rvCorePkg::OP_AUIPC));
    emit(encI(12'd13, 5'd14, 3'b000, 5'd15, rvCorePkg::OP_JALR));
    emit(encI(12'd9, 5'd0, 3'b000, 5'd13, rvCorePkg::OP_IMM));
    storeDword(5'd15, p + 64'd8);
    storeDword(5'd13, 64'd0);

    trapCase(32'h00000073, `CAUSE_ECALL_M, 12'h055);
    trapCase(32'hFFFFFFFF, `CAUSE_ILLEGAL, 12'h066);
    endPc = curPc();
    emit(encJ(21'd0, 5'd0));

    // trap handler that returns past the trapping instruction.
    progIdx = HANDLER_OFF / 4;
    emit(encI(`CSR_MEPC, 5'd0, 3'b010, 5'd20, rvCorePkg::OP_SYSTEM));
    emit(encS(12'h700, 5'd20, 5'd31, 3'b011));
    emit(encI(`CSR_MCAUSE, 5'd0, 3'b010, 5'd21, rvCorePkg::OP_SYSTEM));
    emit(encS(12'h708, 5'd21, 5'd31, 3'b011));
    emit(encI(12'd4, 5'd20, 3'b000, 5'd20, rvCorePkg::OP_IMM));
    emit(encI(`CSR_MEPC, 5'd20, 3'b001, 5'd0, rvCorePkg::OP_SYSTEM));
    emit(32'h30200073);
  endtask

  // ##################################################
  // memory model
  // ##################################################
  task automatic fetchInstruction();
    int idx;
    if ($isunknown(instAddr)) begin
      inst = NOP;
    end else begin
      idx = int'((instAddr - `RESET_PC) >> 2);
      if (instAddr >= `RESET_PC && progImage.exists(idx)) begin
        inst = progImage[idx];
      end else begin
        inst = NOP;
        errors++;
        $display("fetch from %h lies outside the program image", instAddr);
      end
    end
  endtask

  always @(negedge clk) begin
    fetchInstruction();
    #1;
    if (dataRead && dataMem.exists(dataAddr >> 3)) begin
      dataRdata = dataMem[dataAddr >> 3];
    end else begin
      dataRdata = '0;
    end
  end

  task automatic checkStore();
    logic [63:0] ea;
    logic [63:0] ed;
    logic [7:0] em;
    logic [63:0] mb;
    logic [63:0] word;
    if (expAddr.size() == 0) begin
      errors++;
      $display("unexpected store to %h after all expected stores", dataAddr);
    end else begin
      ea = expAddr.pop_front();
      ed = expData.pop_front();
      em = expMask.pop_front();
      mb = maskBits(em);
      assert (dataAddr == ea)
        else begin
          errors++;
          $display("ERR dataAddr got %h expected %h", dataAddr, ea);
        end
      assert (dataMask == em)
        else begin
          errors++;
          $display("ERR dataMask got %h expected %h", dataMask, em);
        end
      assert ((dataWdata & mb) == (ed & mb))
        else begin
          errors++;
          $display("ERR dataWdata got %h expected %h", dataWdata & mb, ed & mb);
        end
    end
    word = dataMem.exists(dataAddr >> 3) ? dataMem[dataAddr >> 3] : 64'd0;
    mb = maskBits(dataMask);
    dataMem[dataAddr >> 3] = (word & ~mb) | (dataWdata & mb);
  endtask

  always @(posedge clk) begin
    if (!reset && dataWrite) begin
      checkStore();
    end
  end

  // ##################################################
  // run control
  // ##################################################
  task automatic waitResetRelease();
    int cycles;
    cycles = 0;
    while (reset && cycles < 100) begin
      @(posedge clk);
      cycles++;
    end
    if (reset) begin
      errors++;
      $display("reset was not released within 100 cycles");
    end
  endtask

  task automatic waitProgramEnd();
    int cycles;
    cycles = 0;
    while (instAddr !== endPc && cycles < 2000) begin
      @(posedge clk);
      cycles++;
    end
    if (instAddr !== endPc) begin
      errors++;
      $display("program did not reach its end address within 2000 cycles");
    end
  endtask

  initial begin
    inst = NOP;
    dataRdata = '0;
    buildProgram();
    waitResetRelease();
    waitProgramEnd();
    repeat (2) @(posedge clk);
    if (expAddr.size() != 0) begin
      errors++;
      $display("%0d expected stores never happened", expAddr.size());
    end
    $display("errors: %0d, assertion failures: %0d", errors, i_dut.i_props.failCount);
    if (errors == 0 && i_dut.i_props.failCount == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+src
src/rvCorePkg.sv
src/regFile.sv
src/instDecoder.sv
src/alu.sv
src/pcUnit.sv
src/csrFile.sv
src/rvCore.sv
verification/clockGen.sv
verification/rvCore_props.sv
verification/rvCoreTb.sv

//--- Bender.yml
package:
  name: rv_core

export_include_dirs:
  - src

sources:
  - files:
      - src/rvCorePkg.sv
      - src/regFile.sv
      - src/instDecoder.sv
      - src/alu.sv
      - src/pcUnit.sv
      - src/csrFile.sv
      - src/rvCore.sv
  - target: simulation
    files:
      - verification/clockGen.sv
      - verification/rvCore_props.sv
      - verification/rvCoreTb.sv
